//--- run.sh
#!/bin/sh
# Build and run the vldu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module vldu_tb -f src.f -o vldu_sim

./obj_dir/vldu_sim

//--- source/vldu.sv
`include "vldu_defines.svh"

module vldu import vldu_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Sequencer
  input  vinsn_t                              vinsn_i,
  input  logic                                vinsn_valid_i,
  output logic                                vinsn_ready_o,
  // Memory read channel
  input  logic [`VLDU_BEAT_BYTES-1:0][7:0]    r_data_i,
  input  logic                                r_valid_i,
  output logic                                r_ready_o,
  // Lane write ports
  output logic [`VLDU_NR_LANES-1:0]           result_req_o,
  output vid_t [`VLDU_NR_LANES-1:0]           result_id_o,
  output vaddr_t [`VLDU_NR_LANES-1:0]         result_addr_o,
  output logic [`VLDU_NR_LANES-1:0][63:0]     result_wdata_o,
  output logic [`VLDU_NR_LANES-1:0][7:0]      result_be_o,
  input  logic [`VLDU_NR_LANES-1:0]           result_gnt_i,
  // Completion per instruction id
  output logic [`VLDU_NR_VINSN-1:0]           vinsn_done_o
);

  localparam int NrLanes = `VLDU_NR_LANES;

  vinsn_t issue_vinsn;
  logic   issue_valid;
  logic   issue_done;
  vinsn_t commit_vinsn;
  logic   commit_valid;
  logic   commit_done;

  // Shared push and per-lane words from the unpacker
  logic                         push;
  lane_payload_t [NrLanes-1:0]  lane_payload;
  logic [NrLanes-1:0]           lane_full;
  logic [NrLanes-1:0]           lane_pop;

  vldu_insn_queue i_insn_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .vinsn_i        (vinsn_i),
    .vinsn_valid_i  (vinsn_valid_i),
    .vinsn_ready_o  (vinsn_ready_o),
    .issue_vinsn_o  (issue_vinsn),
    .issue_valid_o  (issue_valid),
    .issue_done_i   (issue_done),
    .commit_vinsn_o (commit_vinsn),
    .commit_valid_o (commit_valid),
    .commit_done_i  (commit_done)
  );

  vldu_beat_unpack i_beat_unpack (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .r_data_i       (r_data_i),
    .r_valid_i      (r_valid_i),
    .r_ready_o      (r_ready_o),
    .issue_vinsn_i  (issue_vinsn),
    .issue_valid_i  (issue_valid),
    .issue_done_o   (issue_done),
    .lane_full_i    (lane_full),
    .push_o         (push),
    .lane_payload_o (lane_payload)
  );

  // One result queue per lane, each drained by its own grant
  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    lane_payload_t head;

    vldu_lane_queue i_lane_queue (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .push_i    (push),
      .payload_i (lane_payload[l]),
      .full_o    (lane_full[l]),
      .req_o     (result_req_o[l]),
      .payload_o (head),
      .gnt_i     (result_gnt_i[l]),
      .pop_o     (lane_pop[l])
    );

    assign result_id_o[l]    = head.id;
    assign result_addr_o[l]  = head.addr;
    assign result_wdata_o[l] = head.wdata;
    assign result_be_o[l]    = head.be;
  end

  vldu_commit_tracker i_commit_tracker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .commit_vinsn_i (commit_vinsn),
    .commit_valid_i (commit_valid),
    .lane_pop_i     (lane_pop),
    .commit_done_o  (commit_done),
    .vinsn_done_o   (vinsn_done_o)
  );

endmodule

//--- source/vldu_beat_unpack.sv
`include "vldu_defines.svh"

module vldu_beat_unpack import vldu_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Memory read channel
  input  logic [`VLDU_BEAT_BYTES-1:0][7:0]     r_data_i,
  input  logic                                 r_valid_i,
  output logic                                 r_ready_o,
  // Instruction being issued
  input  vinsn_t                               issue_vinsn_i,
  input  logic                                 issue_valid_i,
  output logic                                 issue_done_o,
  // Lane result queues
  input  logic [`VLDU_NR_LANES-1:0]            lane_full_i,
  output logic                                 push_o,
  output lane_payload_t [`VLDU_NR_LANES-1:0]   lane_payload_o
);

  localparam int NrLanes   = `VLDU_NR_LANES;
  localparam int BeatBytes = `VLDU_BEAT_BYTES;
  localparam int WordBytes = NrLanes * 8;
  localparam int VlW       = `VLDU_VL_WIDTH;
  localparam int RPntW     = $clog2(BeatBytes) + 1;
  localparam int WPntW     = $clog2(WordBytes) + 1;

  // Register word being assembled and its byte enables
  logic [WordBytes-1:0][7:0] word_q, word_d;
  logic [WordBytes-1:0]      be_q, be_d;

  // Next byte to read in the beat and next byte to fill in the word
  logic [RPntW-1:0] r_pnt_q, r_pnt_d;
  logic [WPntW-1:0] vrf_pnt_q, vrf_pnt_d;

  // Elements left at the start of the current word
  logic [VlW-1:0] elem_left_q, elem_left_d;
  logic [VlW-1:0] elem_left;
  logic [VlW-1:0] per_word;
  logic [VlW+2:0] bytes_left;

  // Word index inside the instruction
  vaddr_t word_idx_q, word_idx_d;
  vaddr_t row_base;

  logic go;

  // First word takes the count straight from the instruction
  assign elem_left  = (word_idx_q == '0) ? issue_vinsn_i.vl : elem_left_q;
  assign bytes_left = {3'b000, elem_left} << issue_vinsn_i.eew;
  assign per_word   = VlW'(WordBytes >> issue_vinsn_i.eew);
  assign row_base   = vaddr_t'(int'(issue_vinsn_i.vd) * `VLDU_ROWS_PER_VREG);

  // Beat is only taken when every lane can take a word
  assign go = issue_valid_i && r_valid_i && !(|lane_full_i);

  always_comb begin : p_unpack
    int               seq;
    logic [WPntW-1:0] cnt;
    word_d       = word_q;
    be_d         = be_q;
    r_pnt_d      = r_pnt_q;
    vrf_pnt_d    = vrf_pnt_q;
    elem_left_d  = elem_left_q;
    word_idx_d   = word_idx_q;
    push_o       = 1'b0;
    issue_done_o = 1'b0;
    r_ready_o    = 1'b0;
    seq          = 0;
    cnt          = '0;

    if (go) begin
      // Copy beat bytes in order, bounded by the word and the instruction
      for (int i = 0; i < BeatBytes; i++) begin
        seq = int'(vrf_pnt_q) + i - int'(r_pnt_q);
        if (i >= int'(r_pnt_q) && seq < WordBytes && seq < int'(bytes_left)) begin
          word_d[seq[WPntW-2:0]] = r_data_i[i];
          be_d[seq[WPntW-2:0]]   = 1'b1;
          cnt                    = cnt + 1'b1;
        end
      end
      r_pnt_d   = r_pnt_q + RPntW'(cnt);
      vrf_pnt_d = vrf_pnt_q + cnt;

      // Word full or instruction exhausted
      if (int'(vrf_pnt_d) == WordBytes || int'(vrf_pnt_d) >= int'(bytes_left)) begin
        push_o      = 1'b1;
        vrf_pnt_d   = '0;
        word_idx_d  = word_idx_q + 1'b1;
        elem_left_d = (elem_left <= per_word) ? '0 : elem_left - per_word;
        if (elem_left_d == '0) begin
          issue_done_o = 1'b1;
          word_idx_d   = '0;
        end
      end

      // Beat used up, or its tail belongs to nobody
      if (int'(r_pnt_d) == BeatBytes || issue_done_o) begin
        r_ready_o = 1'b1;
        r_pnt_d   = '0;
      end
    end
  end

  // Every lane sees its own 8-byte slice of the word
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      lane_payload_o[l].id    = issue_vinsn_i.id;
      lane_payload_o[l].addr  = row_base + word_idx_q;
      lane_payload_o[l].wdata = word_d[l*8 +: 8];
      lane_payload_o[l].be    = be_d[l*8 +: 8];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_pnt_q     <= '0;
      vrf_pnt_q   <= '0;
      elem_left_q <= '0;
      word_idx_q  <= '0;
      be_q        <= '0;
    end else begin
      r_pnt_q     <= r_pnt_d;
      vrf_pnt_q   <= vrf_pnt_d;
      elem_left_q <= elem_left_d;
      word_idx_q  <= word_idx_d;
      // Fresh word starts with no bytes enabled
      be_q        <= push_o ? '0 : be_d;
    end
  end

  always_ff @(posedge clk_i) begin
    word_q <= word_d;
  end

endmodule

//--- source/vldu_commit_tracker.sv
`include "vldu_defines.svh"

module vldu_commit_tracker import vldu_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Oldest instruction still writing results
  input  vinsn_t                        commit_vinsn_i,
  input  logic                          commit_valid_i,
  // Granted writes per lane
  input  logic [`VLDU_NR_LANES-1:0]     lane_pop_i,
  output logic                          commit_done_o,
  output logic [`VLDU_NR_VINSN-1:0]     vinsn_done_o
);

  localparam int NrLanes   = `VLDU_NR_LANES;
  localparam int NrVinsn   = `VLDU_NR_VINSN;
  localparam int VlW       = `VLDU_VL_WIDTH;
  localparam int WordBytes = NrLanes * 8;
  localparam int WordShift = $clog2(WordBytes);
  localparam int BW        = VlW + 4;
  localparam int WCntW     = BW - WordShift;

  // Words each lane has written since the current instruction began
  logic [NrLanes-1:0][WCntW-1:0] pop_cnt_q, pop_cnt_d;
  logic [NrLanes-1:0][WCntW-1:0] pop_sum;
  logic [NrLanes-1:0]            lane_reached;

  logic [BW-1:0]    bytes_round;
  logic [WCntW-1:0] nr_words;

  // Word count of the instruction, rounded up to whole words
  assign bytes_round = ({4'b0000, commit_vinsn_i.vl} << commit_vinsn_i.eew)
                     + BW'(WordBytes - 1);
  assign nr_words    = WCntW'(bytes_round >> WordShift);

  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      pop_sum[l]      = pop_cnt_q[l] + WCntW'(lane_pop_i[l]);
      lane_reached[l] = (pop_sum[l] >= nr_words);
    end
  end

  // Retire once the slowest lane has written its last word
  assign commit_done_o = commit_valid_i && (&lane_reached);

  // Lanes running ahead keep their surplus for the next instruction
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      pop_cnt_d[l] = commit_done_o ? pop_sum[l] - nr_words : pop_sum[l];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pop_cnt_q    <= '0;
      vinsn_done_o <= '0;
    end else begin
      pop_cnt_q    <= pop_cnt_d;
      // One-hot by id for exactly one cycle
      vinsn_done_o <= commit_done_o ? (NrVinsn'(1) << commit_vinsn_i.id) : '0;
    end
  end

  // Writes only reach the lanes for instructions still in the queue
  a_pop_owner: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|lane_pop_i) |-> commit_valid_i);

endmodule

//--- source/vldu_defines.svh
`ifndef VLDU_DEFINES_SVH
`define VLDU_DEFINES_SVH

// Number of lanes, each one 64 bits wide
`define VLDU_NR_LANES 4

// Bytes carried by one read beat of the memory channel
`define VLDU_BEAT_BYTES 16

// In-flight load instructions
`define VLDU_INSN_DEPTH 4

// Result entries buffered per lane
`define VLDU_RESULT_DEPTH 2

// Instruction ids known to the sequencer
`define VLDU_NR_VINSN 8

// Register-file rows that one vector register takes in each lane
`define VLDU_ROWS_PER_VREG 8

// Bits of the vector length field
`define VLDU_VL_WIDTH 10

`endif

//--- source/vldu_insn_queue.sv
`include "vldu_defines.svh"

module vldu_insn_queue import vldu_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  // Sequencer side
  input  vinsn_t vinsn_i,
  input  logic   vinsn_valid_i,
  output logic   vinsn_ready_o,
  // Issue side towards the beat unpacker
  output vinsn_t issue_vinsn_o,
  output logic   issue_valid_o,
  input  logic   issue_done_i,
  // Commit side towards the tracker
  output vinsn_t commit_vinsn_o,
  output logic   commit_valid_o,
  input  logic   commit_done_i
);

  localparam int Depth = `VLDU_INSN_DEPTH;
  localparam int PntW  = $clog2(Depth);
  localparam int CntW  = PntW + 1;

  // Instruction storage
  vinsn_t [Depth-1:0] mem_q;

  // One pointer per execution phase
  logic [PntW-1:0] accept_pnt_q;
  logic [PntW-1:0] issue_pnt_q;
  logic [PntW-1:0] commit_pnt_q;

  // Instructions still waiting to be issued or committed
  logic [CntW-1:0] issue_cnt_q;
  logic [CntW-1:0] commit_cnt_q;

  logic accept;

  // An entry is freed only once its results are all written
  assign vinsn_ready_o = (commit_cnt_q != CntW'(Depth));
  assign accept        = vinsn_valid_i && vinsn_ready_o;

  assign issue_vinsn_o  = mem_q[issue_pnt_q];
  assign issue_valid_o  = (issue_cnt_q != '0);
  assign commit_vinsn_o = mem_q[commit_pnt_q];
  assign commit_valid_o = (commit_cnt_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      // Depth is a power of two so the pointers wrap on their own
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      if (commit_done_i) begin
        commit_pnt_q <= commit_pnt_q + 1'b1;
      end
      issue_cnt_q  <= issue_cnt_q + CntW'(accept) - CntW'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + CntW'(accept) - CntW'(commit_done_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[accept_pnt_q] <= vinsn_i;
    end
  end

  // Commit never retires an instruction that has not been issued
  a_cnt_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_cnt_q <= commit_cnt_q);

  // Unpacker only finishes an instruction that it was given
  a_issue_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_done_i |-> issue_valid_o);

endmodule

//--- source/vldu_lane_queue.sv
`include "vldu_defines.svh"

module vldu_lane_queue import vldu_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  // Words from the unpacker
  input  logic          push_i,
  input  lane_payload_t payload_i,
  output logic          full_o,
  // Write port towards the lane
  output logic          req_o,
  output lane_payload_t payload_o,
  input  logic          gnt_i,
  // Accepted write for the commit tracker
  output logic          pop_o
);

  localparam int Depth = `VLDU_RESULT_DEPTH;
  localparam int PntW  = $clog2(Depth);
  localparam int CntW  = PntW + 1;

  lane_payload_t [Depth-1:0] mem_q;
  logic [PntW-1:0]           wr_pnt_q;
  logic [PntW-1:0]           rd_pnt_q;
  logic [CntW-1:0]           cnt_q;

  assign full_o    = (cnt_q == CntW'(Depth));
  // Head entry stays put until the lane grants it
  assign req_o     = (cnt_q != '0);
  assign payload_o = mem_q[rd_pnt_q];
  assign pop_o     = req_o && gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_pnt_q <= wr_pnt_q + 1'b1;
      end
      if (pop_o) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + CntW'(push_i) - CntW'(pop_o);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_pnt_q] <= payload_i;
    end
  end

  // Unpacker holds off while any lane is full
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);

  // Lane only grants a pending request
  a_gnt_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_i |-> req_o);

endmodule

//--- source/vldu_pkg.sv
`include "vldu_defines.svh"

package vldu_pkg;

  // Element width as log2 of the element bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } ew_e;

  typedef logic [2:0] vid_t;
  typedef logic [7:0] vaddr_t;

  // Load instruction as handed over by the sequencer
  typedef struct packed {
    vid_t                      id;
    logic [4:0]                vd;
    ew_e                       eew;
    logic [`VLDU_VL_WIDTH-1:0] vl;
  } vinsn_t;

  // One 64-bit write towards a lane register file
  typedef struct packed {
    vid_t       id;
    vaddr_t     addr;
    logic [63:0] wdata;
    logic [7:0] be;
  } lane_payload_t;

endpackage

//--- src.f
+incdir+source
source/vldu_pkg.sv
source/vldu_insn_queue.sv
source/vldu_beat_unpack.sv
source/vldu_lane_queue.sv
source/vldu_commit_tracker.sv
source/vldu.sv
testbench/vldu_tb.sv

//--- testbench/vldu_cases.txt
# Columns: id vd eew vl base, with base in hex and the others decimal
# eew is log2 of the element bytes; the last four lines run with grants held off
0 1 0 32 00
1 2 1 5 10
2 3 3 12 a5
3 4 2 20 3c
4 5 0 7 f0
5 6 1 40 81
6 7 2 3 5e
7 8 3 4 c3
0 10 0 100 17
1 12 3 31 e2
2 0 1 24 99
3 31 2 8 44
4 9 2 16 6b
5 11 0 50 d4
6 13 3 10 2f
7 15 1 9 b8

//--- testbench/vldu_tb.sv
`include "vldu_defines.svh"

module vldu_tb import vldu_pkg::*; ();

  localparam int NrLanes   = `VLDU_NR_LANES;
  localparam int BeatBytes = `VLDU_BEAT_BYTES;
  localparam int NrVinsn   = `VLDU_NR_VINSN;
  localparam int WordBytes = NrLanes * 8;
  localparam int HoldGroup = 4;
  localparam int HoldCycles = 50;
  localparam int Timeout   = 2000;

  // Expected lane result, tagged with the cases-file line it belongs to
  typedef struct packed {
    logic [7:0]    idx;
    lane_payload_t p;
  } expect_t;

  logic                         clk_i = 1'b0;
  logic                         rst_ni;
  vinsn_t                       vinsn_i;
  logic                         vinsn_valid_i;
  logic                         vinsn_ready_o;
  logic [BeatBytes-1:0][7:0]    r_data_i;
  logic                         r_valid_i;
  logic                         r_ready_o;
  logic [NrLanes-1:0]           result_req_o;
  vid_t [NrLanes-1:0]           result_id_o;
  vaddr_t [NrLanes-1:0]         result_addr_o;
  logic [NrLanes-1:0][63:0]     result_wdata_o;
  logic [NrLanes-1:0][7:0]      result_be_o;
  logic [NrLanes-1:0]           result_gnt_i;
  logic [NrVinsn-1:0]           vinsn_done_o;

  // Instructions from the cases file
  int case_id[$];
  int case_vd[$];
  int case_eew[$];
  int case_vl[$];
  int case_base[$];

  // Lane writes still owed per instruction, and results owed per lane
  int      words_left[$];
  expect_t exp_q[NrLanes][$];

  logic [NrLanes-1:0] req_seen;
  logic [NrVinsn-1:0] done_next;
  int                 done_count;
  logic               hold_gnt;

  vldu vldu_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .vinsn_i        (vinsn_i),
    .vinsn_valid_i  (vinsn_valid_i),
    .vinsn_ready_o  (vinsn_ready_o),
    .r_data_i       (r_data_i),
    .r_valid_i      (r_valid_i),
    .r_ready_o      (r_ready_o),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i),
    .vinsn_done_o   (vinsn_done_o)
  );

  always #4 clk_i = ~clk_i;

  task automatic fail_now();
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
               $time, name, expected, actual);
      fail_now();
    end
  endtask

  task automatic read_cases();
    int    fd;
    int    got;
    int    n;
    int    id, vd, eew, vl, base;
    string line;
    fd = $fopen("testbench/vldu_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open testbench/vldu_cases.txt");
      fail_now();
    end
    while (!$feof(fd)) begin
      got = $fgets(line, fd);
      if (got != 0) begin
        // Comment and blank lines do not scan as five fields
        n = $sscanf(line, "%d %d %d %d %h", id, vd, eew, vl, base);
        if (n == 5) begin
          case_id.push_back(id);
          case_vd.push_back(vd);
          case_eew.push_back(eew);
          case_vl.push_back(vl);
          case_base.push_back(base);
        end
      end
    end
    $fclose(fd);
    if (case_id.size() <= HoldGroup) begin
      $display("Cases file holds too few instructions");
      fail_now();
    end
  endtask

  // Word w of lane l holds stream bytes 32w+8l up to 32w+8l+7
  task automatic build_model();
    int      c, w, l, j, k;
    int      nbytes, nwords;
    expect_t e;
    for (c = 0; c < case_id.size(); c++) begin
      nbytes = case_vl[c] << case_eew[c];
      nwords = (nbytes + WordBytes - 1) / WordBytes;
      words_left.push_back(nwords * NrLanes);
      for (w = 0; w < nwords; w++) begin
        for (l = 0; l < NrLanes; l++) begin
          e        = '0;
          e.idx    = 8'(c);
          e.p.id   = vid_t'(case_id[c]);
          e.p.addr = vaddr_t'(case_vd[c] * 8 + w);
          for (j = 0; j < 8; j++) begin
            k = w * WordBytes + l * 8 + j;
            if (k < nbytes) begin
              e.p.wdata[j*8 +: 8] = 8'(case_base[c] + k);
              e.p.be[j]           = 1'b1;
            end
          end
          exp_q[l].push_back(e);
        end
      end
    end
  endtask

  task automatic send_insns(input int first, input int last);
    int     i;
    int     cycles;
    vinsn_t v;
    for (i = first; i < last; i++) begin
      v.id          = vid_t'(case_id[i]);
      v.vd          = 5'(case_vd[i]);
      v.eew         = ew_e'(case_eew[i][1:0]);
      v.vl          = `VLDU_VL_WIDTH'(case_vl[i]);
      vinsn_i       <= v;
      vinsn_valid_i <= 1'b1;
      cycles = 0;
      @(negedge clk_i);
      while (!vinsn_ready_o) begin
        cycles++;
        if (cycles > Timeout) begin
          $display("Timeout waiting for the instruction queue to accept line %0d", i);
          fail_now();
        end
        @(negedge clk_i);
      end
      @(posedge clk_i);
    end
    vinsn_valid_i <= 1'b0;
  endtask

  // Beats are padded with stream bytes up to the beat boundary
  task automatic send_beats(input int first, input int last);
    int                        i, b, k;
    int                        nbeats;
    int                        cycles;
    logic [BeatBytes-1:0][7:0] beat;
    for (i = first; i < last; i++) begin
      nbeats = ((case_vl[i] << case_eew[i]) + BeatBytes - 1) / BeatBytes;
      for (b = 0; b < nbeats; b++) begin
        for (k = 0; k < BeatBytes; k++) begin
          beat[k] = 8'(case_base[i] + b * BeatBytes + k);
        end
        r_data_i  <= beat;
        r_valid_i <= 1'b1;
        cycles = 0;
        @(negedge clk_i);
        while (!r_ready_o) begin
          cycles++;
          if (cycles > Timeout) begin
            $display("Timeout waiting for beat %0d of line %0d to be taken", b, i);
            fail_now();
          end
          @(negedge clk_i);
        end
        @(posedge clk_i);
      end
    end
    r_valid_i <= 1'b0;
  endtask

  // Full queue with no grants must keep the sequencer stalled
  task automatic hold_grants();
    int i;
    for (i = 0; i < HoldCycles; i++) begin
      @(negedge clk_i);
      check_value("vinsn_ready_o", 64'(0), 64'(vinsn_ready_o));
    end
    @(posedge clk_i);
    hold_gnt <= 1'b0;
  endtask

  task automatic wait_all_done(input int target);
    int cycles;
    cycles = 0;
    while (done_count < target) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > Timeout) begin
        $display("Timeout with %0d of %0d instructions done", done_count, target);
        fail_now();
      end
    end
  endtask

  // A grant is only given after a cycle with a request and no grant,
  // so the request is still pending when the grant lands
  always @(posedge clk_i) begin : grant_drive
    int   l;
    logic coin;
    for (l = 0; l < NrLanes; l++) begin
      coin = ($urandom % 4) != 0;
      if (!rst_ni || hold_gnt) begin
        result_gnt_i[l] <= 1'b0;
      end else begin
        result_gnt_i[l] <= req_seen[l] && !result_gnt_i[l] && coin;
      end
    end
  end

  always @(negedge clk_i) begin : result_monitor
    int                 l, j;
    expect_t            e;
    logic [63:0]        mask;
    logic [NrVinsn-1:0] done_now;
    if (rst_ni) begin
      // Done shows up one cycle after the last grant
      check_value("vinsn_done_o", 64'(done_next), 64'(vinsn_done_o));
      if (done_next != '0) begin
        done_count++;
      end
      done_now = '0;
      for (l = 0; l < NrLanes; l++) begin
        if (result_req_o[l] && result_gnt_i[l]) begin
          if (exp_q[l].size() == 0) begin
            $display("Lane %0d was granted a result that no instruction owes", l);
            fail_now();
          end
          e = exp_q[l].pop_front();
          check_value($sformatf("result_id_o[%0d]", l), 64'(e.p.id), 64'(result_id_o[l]));
          check_value($sformatf("result_addr_o[%0d]", l), 64'(e.p.addr),
                      64'(result_addr_o[l]));
          check_value($sformatf("result_be_o[%0d]", l), 64'(e.p.be), 64'(result_be_o[l]));
          // Disabled bytes carry no data
          for (j = 0; j < 8; j++) begin
            mask[j*8 +: 8] = {8{e.p.be[j]}};
          end
          check_value($sformatf("result_wdata_o[%0d]", l), e.p.wdata,
                      result_wdata_o[l] & mask);
          words_left[e.idx]--;
          if (words_left[e.idx] == 0) begin
            done_now[case_id[e.idx]] = 1'b1;
          end
        end
      end
      done_next = done_now;
    end
    req_seen = result_req_o;
  end

  initial begin : main_sequence
    int n;
    int i;
    rst_ni        = 1'b0;
    vinsn_i       = '0;
    vinsn_valid_i = 1'b0;
    r_data_i      = '0;
    r_valid_i     = 1'b0;
    result_gnt_i  = '0;
    hold_gnt      = 1'b0;
    req_seen      = '0;
    done_next     = '0;
    done_count    = 0;
    void'($urandom(34));

    read_cases();
    build_model();
    n = case_id.size();

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Idle unit stays quiet
    for (i = 0; i < 5; i++) begin
      @(negedge clk_i);
      check_value("r_ready_o", 64'(0), 64'(r_ready_o));
      check_value("result_req_o", 64'(0), 64'(result_req_o));
      check_value("vinsn_done_o", 64'(0), 64'(vinsn_done_o));
    end
    @(posedge clk_i);

    // Random grants over most of the cases
    fork
      send_insns(0, n - HoldGroup);
      send_beats(0, n - HoldGroup);
    join
    wait_all_done(n - HoldGroup);

    // Last group fills the queue while grants are held off
    hold_gnt <= 1'b1;
    fork
      begin
        send_insns(n - HoldGroup, n);
        hold_grants();
      end
      send_beats(n - HoldGroup, n);
    join
    wait_all_done(n);

    // Drained unit has no pending writes and takes instructions again
    @(negedge clk_i);
    check_value("result_req_o", 64'(0), 64'(result_req_o));
    check_value("r_ready_o", 64'(0), 64'(r_ready_o));
    check_value("vinsn_ready_o", 64'(1), 64'(vinsn_ready_o));
    $display("Test completed successfully");
    $finish;
  end

endmodule
